// ==== Makefile ====
TOP := fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== dv/fetch_assert.sv ====
/*
 * fetch unit port assertions
 * request alignment, output hold on stall, jumping flag after a jump
 */
`default_nettype none

module fetch_assert (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  enable_i,
    input fetch_pkg::jump_req_t  jump_i,
    input fetch_pkg::imem_req_t  imem_req_o,
    input fetch_pkg::fetch_out_t out_o,
    input logic                  valid_o,
    input logic                  jumping_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    addr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        imem_req_o.addr[1:0] == 2'b00)
        else $error("fetch request address not word aligned");

    // registered outputs stay put while decode stalls
    out_held: assert property (@(posedge clk) disable iff (!reset_n)
        !enable_i |=> $stable(out_o) && $stable(valid_o))
        else $error("fetch outputs changed while decode stalled");

    jump_flag: assert property (@(posedge clk) disable iff (!reset_n)
        jump_i.taken |=> jumping_o)
        else $error("jumping flag not set after a taken jump");

endmodule

bind fetch_unit fetch_assert u_assert (
    .clk        (clk),
    .reset_n    (reset_n),
    .enable_i   (enable_i),
    .jump_i     (jump_i),
    .imem_req_o (imem_req_o),
    .out_o      (out_o),
    .valid_o    (valid_o),
    .jumping_o  (jumping_o)
);

`default_nettype wire

// ==== dv/fetch_tb.sv ====
/*
 * fetch unit testbench
 * memory model, random busy and decode stalls, jumps, reference compare
 */
`default_nettype none

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam int STREAM_N = 40;   // checks per test
    localparam int BUSY_N   = 60;
    localparam int STALL_N  = 60;
    localparam int JUMP_N   = 8;    // jumps with a few checks after each
    localparam int BUDGET   = 20 + 2*STREAM_N + 4*BUSY_N + 6*STALL_N + 60*JUMP_N + 200;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       enable_i;
    jump_req_t  jump_i;
    logic       busy_i;
    word_t      imem_data_i = '0;
    imem_req_t  imem_req_o;
    fetch_out_t out_o;
    logic       valid_o;
    logic       jumping_o;

    word_t      mem_addr   = START_ADDR;   // last accepted request
    word_t      exp_pc     = START_ADDR;
    logic       jump_wait  = 1'b0;         // target not yet taken by decode
    logic       was_held   = 1'b0;
    fetch_out_t held_out   = '0;
    int         n_checks   = 0;
    int         n_errors   = 0;
    int         n_tests    = 0;
    int         busy_pct   = 0;
    int         stall_pct  = 0;
    int         stall_left = 0;
    string      test_name  = "reset";

    fetch_unit UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .jump_i      (jump_i),
        .busy_i      (busy_i),
        .imem_data_i (imem_data_i),
        .imem_req_o  (imem_req_o),
        .out_o       (out_o),
        .valid_o     (valid_o),
        .jumping_o   (jumping_o)
    );

    always #5 clk = ~clk;

    // instruction memory contents as a fixed scramble of the address
    function automatic word_t ref_word(input word_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h0000_0013;
    endfunction

    task automatic check_val(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            n_errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // memory answers one cycle after an accepted request
    always @(posedge clk)
        if (imem_req_o.en && !busy_i)
            mem_addr <= imem_req_o.addr;

    always @(negedge clk)
        imem_data_i = ref_word(mem_addr);

    // every instruction taken by decode is compared here
    always @(posedge clk) begin
        if (reset_n) begin
            if (was_held) begin     // decode stalled last edge
                check_val("held pc", held_out.pc, out_o.pc);
                check_val("held instr", held_out.instr, out_o.instr);
            end
            if (valid_o && enable_i) begin
                check_val("pc", exp_pc, out_o.pc);
                check_val("instr", ref_word(exp_pc), out_o.instr);
                check_val("jumping", '0, word_t'(jumping_o));  // target already taken
                exp_pc = exp_pc + 32'd4;
                n_checks++;
                jump_wait = 1'b0;
            end else if (jump_wait && !valid_o) begin
                check_val("jumping", word_t'(1), word_t'(jumping_o));
            end
            if (jump_i.taken) begin
                exp_pc    = jump_i.target;  // stream restarts here
                jump_wait = 1'b1;
            end
            was_held = !enable_i;
            held_out = out_o;
        end
    end

    // random busy and stall runs of 1 to 5 cycles
    task automatic next_cycle();
        @(negedge clk);
        jump_i = '0;
        busy_i = ($urandom_range(99) < busy_pct);
        if (stall_left > 0) begin
            enable_i = 1'b0;
            stall_left--;
        end else if ($urandom_range(99) < stall_pct) begin
            enable_i   = 1'b0;
            stall_left = $urandom_range(4);
        end else begin
            enable_i = 1'b1;
        end
    endtask

    task automatic run_checks(input int n);
        int goal;
        goal = n_checks + n;
        while (n_checks < goal)
            next_cycle();
    endtask

    // fill parks decode so the queue fills, then jumps with memory busy
    task automatic jump_to(input word_t dest, input logic fill);
        if (fill) begin
            repeat (6) begin
                @(negedge clk);
                enable_i = 1'b0;
                busy_i   = 1'b0;
            end
        end
        @(negedge clk);
        enable_i     = 1'b1;
        busy_i       = fill;
        stall_left   = 0;
        jump_i.taken  = 1'b1;
        jump_i.target = dest;
        next_cycle();
        while (jump_wait)
            next_cycle();
    endtask

    task automatic check_reset_values();
        check_val("valid", '0, word_t'(valid_o));
        check_val("pc", START_ADDR, out_o.pc);
        check_val("instr", NOP_INSTR, out_o.instr);
        check_val("jumping", word_t'(1), word_t'(jumping_o));
    endtask

    task automatic finish_test(input int err_before);
        n_tests++;
        $display("test %s done, %0d errors", test_name, n_errors - err_before);
    endtask

    initial begin
        int    err0;
        word_t dest;
        void'($urandom(32'ha308f276));
        reset_n  = 1'b0;
        enable_i = 1'b0;
        jump_i   = '0;
        busy_i   = 1'b0;

        err0 = n_errors;
        repeat (10) @(negedge clk);
        check_reset_values();
        reset_n = 1'b1;
        #1 check_reset_values();
        check_val("req en", word_t'(1), word_t'(imem_req_o.en));
        finish_test(err0);

        err0      = n_errors;
        test_name = "stream";
        run_checks(STREAM_N);
        finish_test(err0);

        err0      = n_errors;
        test_name = "busy";
        busy_pct  = 35;
        run_checks(BUSY_N);
        finish_test(err0);

        err0      = n_errors;
        test_name = "stall";
        busy_pct  = 0;
        stall_pct = 25;
        run_checks(STALL_N);
        finish_test(err0);

        err0      = n_errors;
        test_name = "jump";
        busy_pct  = 20;
        stall_pct = 15;
        for (int i = 0; i < JUMP_N; i++) begin
            dest = $urandom & 32'hffff_fffc;
            jump_to(dest, (i % 2) == 1);
            run_checks(5);  // stepping resumes from the target
        end
        finish_test(err0);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        repeat (BUDGET) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", BUDGET);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_addr_gen.sv ====
/*
 * fetch address generator
 * holds the fetch address, issues memory requests and filters returned
 * words, then steers them into the instruction queue or straight to issue
 */
`default_nettype none

module fetch_addr_gen (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,       // decode takes an instruction
    input  fetch_pkg::jump_req_t  jump_i,
    input  logic                  busy_i,         // memory refuses the request
    input  fetch_pkg::word_t      imem_data_i,
    input  logic                  full_i,
    input  logic                  almost_full_i,
    input  logic                  head_valid_i,   // queue holds a word
    output fetch_pkg::imem_req_t  imem_req_o,
    output fetch_pkg::fetch_word_t mem_word_o,
    output logic                  push_o,
    output logic                  pop_o,
    output logic                  flush_o
);
    import fetch_pkg::*;

    word_t fetch_addr;  // address of the current request
    logic  busy_r;      // no word comes back this cycle
    logic  jumped_r;    // a jump happened last cycle
    logic  room;
    logic  req_en;
    logic  accepted;

    // decode consumption pops the queue, a taken jump empties it
    assign pop_o   = enable_i;
    assign flush_o = jump_i.taken;

    // returned word only counts if its request was accepted and not
    // overtaken by a jump, either last cycle or this one
    assign mem_word_o.valid = !busy_r && !jumped_r && !jump_i.taken;
    assign mem_word_o.data  = imem_data_i;

    // queue it unless issue takes it straight from memory
    assign push_o = mem_word_o.valid && (!enable_i || head_valid_i);

    // a new request is safe if its answer still fits next cycle
    // the word arriving now may take the last free slot
    assign room   = !full_i && !(almost_full_i && mem_word_o.valid);
    assign req_en = enable_i || room;   // a pop frees a slot anyway

    assign imem_req_o.en   = req_en;
    assign imem_req_o.addr = fetch_addr;

    // address holds while memory is busy or the queue has no room
    // and moves on once the held request is taken
    assign accepted = req_en && !busy_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_r <= 1'b1;     // nothing in flight out of reset
        end else begin
            busy_r <= !accepted;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r <= 1'b1;
        end else begin
            jumped_r <= jump_i.taken;   // drop the word of the old stream
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_addr <= START_ADDR;
        end else if (jump_i.taken) begin
            fetch_addr <= {jump_i.target[XLEN-1:2], 2'b00};  // redirect, word aligned
        end else if (accepted) begin
            fetch_addr <= fetch_addr + INSTR_BYTES;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
/*
 * fetch unit shared constants and types
 * word, jump, memory request and decode-side structs
 */
`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;   // address and instruction width

    typedef logic [XLEN-1:0] word_t;

    localparam word_t START_ADDR  = '0;             // pc after reset
    localparam word_t NOP_INSTR   = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t INSTR_BYTES = word_t'(4);     // pc step per instruction

    // instruction queue sizing
    localparam int IQUEUE_DEPTH      = 2;
    localparam int ALMOST_FULL_LEVEL = 1;   // free entries left when almost full

    // taken jump from decode, one cycle strobe
    typedef struct packed {
        logic  taken;
        word_t target;
    } jump_req_t;

    // request to instruction memory
    typedef struct packed {
        logic  en;
        word_t addr;    // word aligned
    } imem_req_t;

    // instruction word with its valid bit
    typedef struct packed {
        logic  valid;
        word_t data;
    } fetch_word_t;

    // registered fetch result toward decode
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_out_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
/*
 * instruction fetch unit top
 * address generator feeding an instruction queue and the issue register
 */
`default_nettype none

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  fetch_pkg::jump_req_t  jump_i,
    input  logic                  busy_i,
    input  fetch_pkg::word_t      imem_data_i,
    output fetch_pkg::imem_req_t  imem_req_o,
    output fetch_pkg::fetch_out_t out_o,
    output logic                  valid_o,
    output logic                  jumping_o
);
    import fetch_pkg::*;

    fetch_word_t mem_word;  // filtered memory answer
    fetch_word_t head;      // oldest queued word
    logic        push;
    logic        pop;
    logic        flush;
    logic        full;
    logic        almost_full;

    fetch_addr_gen u_addr_gen (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .jump_i        (jump_i),
        .busy_i        (busy_i),
        .imem_data_i   (imem_data_i),
        .full_i        (full),
        .almost_full_i (almost_full),
        .head_valid_i  (head.valid),
        .imem_req_o    (imem_req_o),
        .mem_word_o    (mem_word),
        .push_o        (push),
        .pop_o         (pop),
        .flush_o       (flush)
    );

    instr_queue #(
        .DEPTH (IQUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush_i       (flush),
        .push_i        (push),
        .pop_i         (pop),
        .data_i        (mem_word.data),
        .head_o        (head),
        .full_o        (full),
        .almost_full_o (almost_full)
    );

    issue_stage u_issue (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable_i   (enable_i),
        .jump_i     (jump_i),
        .head_i     (head),
        .mem_word_i (mem_word),
        .out_o      (out_o),
        .valid_o    (valid_o),
        .jumping_o  (jumping_o)
    );

endmodule

`default_nettype wire

// ==== rtl/instr_queue.sv ====
/*
 * instruction queue
 * small ring buffer between memory and issue, with full and almost full
 */
`default_nettype none

module instr_queue #(
    parameter int DEPTH = fetch_pkg::IQUEUE_DEPTH
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   flush_i,
    input  logic                   push_i,
    input  logic                   pop_i,
    input  fetch_pkg::word_t       data_i,
    output fetch_pkg::fetch_word_t head_o,
    output logic                   full_o,
    output logic                   almost_full_o
);
    import fetch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;    // occupied entries
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, not at a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // flush wins over both, pop on empty is ignored
    assign do_pop  = pop_i && head_o.valid && !flush_i;
    assign do_push = push_i && (!full_o || do_pop) && !flush_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_i;
    end

    assign head_o.valid  = (count != '0);
    assign head_o.data   = mem[rd_ptr];     // written word shows next cycle
    assign full_o        = (count == CNT_W'(DEPTH));
    assign almost_full_o = (count >= CNT_W'(DEPTH - ALMOST_FULL_LEVEL));

endmodule

`default_nettype wire

// ==== rtl/issue_stage.sv ====
/*
 * issue register
 * picks the oldest valid word and registers pc, instruction and valid
 * toward decode, tracking jump targets for the pc
 */
`default_nettype none

module issue_stage (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  fetch_pkg::jump_req_t   jump_i,
    input  fetch_pkg::fetch_word_t head_i,
    input  fetch_pkg::fetch_word_t mem_word_i,
    output fetch_pkg::fetch_out_t  out_o,
    output logic                   valid_o,
    output logic                   jumping_o
);
    import fetch_pkg::*;

    word_t jump_pc;         // target for the next issued pc
    logic  jump_pending;    // next taken word starts the new stream
    logic  head_ok;
    logic  instr_valid;
    logic  take;
    word_t instr_sel;
    word_t next_pc;

    // queued word is stale once a jump flushes it
    assign head_ok     = head_i.valid && !jump_i.taken;
    assign instr_valid = head_ok || mem_word_i.valid;

    // queue holds older words than memory
    assign instr_sel = head_ok ? head_i.data : mem_word_i.data;
    assign take      = enable_i && instr_valid;
    assign next_pc   = jump_pending ? jump_pc : out_o.pc + INSTR_BYTES;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            jump_pc <= START_ADDR;  // reset acts as a jump to the start
        else if (jump_i.taken)
            jump_pc <= jump_i.target;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            jump_pending <= 1'b1;
        else if (jump_i.taken)
            jump_pending <= 1'b1;
        else if (take)
            jump_pending <= 1'b0;   // first target word issued
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            valid_o <= 1'b0;
        else if (enable_i)
            valid_o <= instr_valid;     // holds while decode stalls
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_o.pc    <= START_ADDR;
            out_o.instr <= NOP_INSTR;
        end else if (take) begin
            out_o.pc    <= next_pc;
            out_o.instr <= instr_sel;
        end
    end

    // decode waits on this until the target arrives
    assign jumping_o = jump_pending;

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/fetch_pkg.sv
rtl/fetch_addr_gen.sv
rtl/instr_queue.sv
rtl/issue_stage.sv
rtl/fetch_unit.sv
dv/fetch_assert.sv
dv/fetch_tb.sv
